// File: sim.f
verilog/matmul_pkg.sv
verilog/host_pkg.sv
verilog/operand_ram.sv
verilog/processing_element.sv
verilog/systolic_array.sv
verilog/operand_feeder.sv
verilog/result_drain.sv
verilog/matmul_top.sv
tests/matmul_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -f sim.f --top-module matmul_tb -o matmul_sim \
  > build.log 2>&1 &&
{ ./obj_dir/matmul_sim > sim.log 2>&1 || true; } &&
grep -q '^Simulation passed$' sim.log &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

// File: tests/matmul_tb.sv
`timescale 1ns/10ps

module matmul_tb;

  localparam int DIM = matmul_pkg::ARRAY_DIM;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 3;
  localparam int N_TABLE = 3;
  localparam int N_RANDOM = 4;
  localparam int N_CASES = N_TABLE + N_RANDOM;
  localparam int CASE_CYCLES = 60;
  localparam int DONE_TIMEOUT = 40;

  // row-major, element (i, j) at i*DIM + j, row 0 written first
  typedef matmul_pkg::elem_t [0:DIM*DIM-1] mat_t;

  logic clk;
  logic reset;
  logic start;
  logic done;
  host_pkg::host_cmd_t host_cmd;
  host_pkg::read_rsp_t read_rsp;

  mat_t tab_a [N_TABLE];
  mat_t tab_b [N_TABLE];
  mat_t tab_c [N_TABLE];
  mat_t cur_a;
  mat_t cur_b;
  mat_t cur_c;

  // expected read words in issue order, the monitor walks them with rsp_count
  matmul_pkg::lane_word_t rsp_expect [$];
  int rsp_count = 0;
  int starts_issued = 0;
  int dones_seen = 0;
  logic done_last = 1'b0;
  logic rc_d1;
  logic rc_d2;

  matmul_top #(.MEM_DEPTH(128)) dut_i (
    .clk      (clk),
    .reset    (reset),
    .host_cmd (host_cmd),
    .start    (start),
    .read_rsp (read_rsp),
    .done     (done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic issue_cmd(input host_pkg::host_cmd_t cmd);
    @(posedge clk);
    host_cmd <= cmd;
  endtask

  task automatic fill_table();
    // identity times B gives B back
    tab_a[0] = {64'h0001_0000_0000_0000, 64'h0000_0001_0000_0000,
                64'h0000_0000_0001_0000, 64'h0000_0000_0000_0001};
    tab_b[0] = {64'h1234_0042_beef_0007, 64'h00ff_fffe_0100_8000,
                64'h0003_5555_aaaa_0001, 64'h7fff_0010_0c0c_ffff};
    tab_c[0] = tab_b[0];
    // small integers, product worked out by hand
    tab_a[1] = {64'h0001_0002_0003_0004, 64'h0005_0006_0007_0008,
                64'h0009_000a_000b_000c, 64'h000d_000e_000f_0010};
    tab_b[1] = {64'h0002_0000_0000_0001, 64'h0000_0001_0003_0000,
                64'h0001_0001_0000_0000, 64'h0000_0000_0001_0002};
    tab_c[1] = {64'h0005_0005_000a_0009, 64'h0011_000d_001a_0015,
                64'h001d_0015_002a_0021, 64'h0029_001d_003a_002d};
    // saturating cells mixed with exact ones near the limit
    tab_a[2] = {64'h0100_0100_0100_0100, 64'h0001_0000_0000_0000,
                64'hffff_0000_0000_0000, 64'h00ff_00ff_0000_0000};
    tab_b[2] = {64'h0100_0001_8001_0000, 64'h0100_0000_0000_0000,
                64'h0100_0000_0000_0000, 64'h0100_0000_0000_0000};
    tab_c[2] = {64'hffff_0100_ffff_0000, 64'h0100_0001_8001_0000,
                64'hffff_ffff_ffff_0000, 64'hffff_00ff_ffff_0000};
  endtask

  task automatic randomize_operands();
    for (int n = 0; n < DIM*DIM; n++) begin
      cur_a[n] = matmul_pkg::elem_t'($urandom_range(0, 255));
      cur_b[n] = matmul_pkg::elem_t'($urandom_range(0, 255));
    end
  endtask

  // C = A*B with 32-bit sums, clipped to all ones past 16 bits
  task automatic compute_reference();
    logic [31:0] sum;
    for (int i = 0; i < DIM; i++) begin
      for (int j = 0; j < DIM; j++) begin
        sum = '0;
        for (int k = 0; k < DIM; k++) begin
          sum = sum + 32'(cur_a[i*DIM+k]) * 32'(cur_b[k*DIM+j]);
        end
        cur_c[i*DIM+j] = (sum[31:16] != '0) ? 16'hffff : sum[15:0];
      end
    end
  endtask

  // word k of A is column k, word k of B is row k
  task automatic load_operands();
    host_pkg::host_cmd_t cmd;
    for (int k = 0; k < DIM; k++) begin
      cmd = '0;
      cmd.write_a = 1'b1;
      cmd.addr = matmul_pkg::addr_t'(k);
      for (int i = 0; i < DIM; i++) begin
        cmd.data[i] = cur_a[i*DIM+k];
      end
      issue_cmd(cmd);
      cmd = '0;
      cmd.write_b = 1'b1;
      cmd.addr = matmul_pkg::addr_t'(k);
      for (int j = 0; j < DIM; j++) begin
        cmd.data[j] = cur_b[k*DIM+j];
      end
      issue_cmd(cmd);
    end
    issue_cmd('0);
  endtask

  task automatic run_once();
    int cycles;
    cycles = 0;
    @(posedge clk);
    start <= 1'b1;
    starts_issued = starts_issued + 1;
    @(posedge clk);
    start <= 1'b0;
    while (dones_seen < starts_issued) begin
      @(posedge clk);
      cycles = cycles + 1;
      assert (cycles < DONE_TIMEOUT)
        else abort_run($sformatf("no done within %0d cycles of start", DONE_TIMEOUT));
    end
  endtask

  // word j of C is column j, lane i = C[i][j]
  task automatic read_and_check();
    host_pkg::host_cmd_t cmd;
    matmul_pkg::lane_word_t col_word;
    for (int j = 0; j < DIM; j++) begin
      cmd = '0;
      cmd.read_c = 1'b1;
      cmd.addr = matmul_pkg::addr_t'(j);
      for (int i = 0; i < DIM; i++) begin
        col_word[i] = cur_c[i*DIM+j];
      end
      rsp_expect.push_back(col_word);
      issue_cmd(cmd);
    end
    issue_cmd('0);
    while (rsp_count < rsp_expect.size()) begin
      @(posedge clk);
    end
  endtask

  // read_c history, valid must follow it by two cycles
  always @(posedge clk) begin
    if (reset) begin
      rc_d1 <= 1'b0;
      rc_d2 <= 1'b0;
    end else begin
      rc_d1 <= host_cmd.read_c;
      rc_d2 <= rc_d1;
    end
  end

  // outputs checked at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      assert (read_rsp.valid == rc_d2)
        else abort_run($sformatf("MISMATCH read_rsp.valid expected %h got %h",
                                 rc_d2, read_rsp.valid));
      if (read_rsp.valid) begin
        assert (read_rsp.data == rsp_expect[rsp_count])
          else abort_run($sformatf("MISMATCH read_rsp.data expected %h got %h",
                                   rsp_expect[rsp_count], read_rsp.data));
        rsp_count = rsp_count + 1;
      end
      assert (!(done && done_last))
        else abort_run("done stayed high for more than one cycle");
      if (done) begin
        assert (dones_seen < starts_issued)
          else abort_run("done pulsed without a pending start");
        dones_seen = dones_seen + 1;
      end
      done_last = done;
    end
  end

  initial begin
    repeat (RESET_CYCLES + N_CASES * CASE_CYCLES) @(posedge clk);
    abort_run("watchdog expired before all cases finished");
  end

  initial begin
    void'($urandom(81));
    reset = 1'b1;
    start = 1'b0;
    host_cmd = '0;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    // quiet stretch, the monitor sees done and valid held low
    repeat (4) @(posedge clk);
    for (int n = 0; n < N_CASES; n++) begin
      if (n < N_TABLE) begin
        cur_a = tab_a[n];
        cur_b = tab_b[n];
        cur_c = tab_c[n];
      end else begin
        randomize_operands();
        compute_reference();
      end
      load_operands();
      run_once();
      read_and_check();
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: verilog/matmul_top.sv
`timescale 1ns/10ps

module matmul_top #(
  parameter int MEM_DEPTH = matmul_pkg::MEM_DEPTH
) (
  input  logic                clk,
  input  logic                reset,
  input  host_pkg::host_cmd_t host_cmd,
  input  logic                start,
  output host_pkg::read_rsp_t read_rsp,
  output logic                done
);

  localparam int DIM = matmul_pkg::ARRAY_DIM;

  logic busy;
  logic run_start;
  logic rd_pend_q;
  logic rsp_valid_q;
  matmul_pkg::addr_t rd_addr_q;
  matmul_pkg::addr_t feed_addr;
  matmul_pkg::addr_t drain_addr;
  matmul_pkg::addr_t ab_addr;
  matmul_pkg::addr_t c_addr;
  matmul_pkg::lane_word_t a_rdata;
  matmul_pkg::lane_word_t b_rdata;
  matmul_pkg::lane_word_t c_rdata;
  matmul_pkg::lane_word_t c_wdata;
  matmul_pkg::lane_word_t a_lanes;
  matmul_pkg::lane_word_t b_lanes;
  logic clear;
  logic capture;
  logic c_we;
  matmul_pkg::elem_t [DIM*DIM-1:0] results;

  assign run_start = start && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (run_start) begin
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;
    end
  end

  // read path: address register, then memory register
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pend_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rd_pend_q <= host_cmd.read_c;
      rsp_valid_q <= rd_pend_q;
    end
  end

  always_ff @(posedge clk) begin
    if (host_cmd.read_c) begin
      rd_addr_q <= host_cmd.addr;
    end
  end

  // run owns the address ports while busy
  assign ab_addr = busy ? feed_addr : host_cmd.addr;
  assign c_addr = busy ? drain_addr : rd_addr_q;

  assign read_rsp = '{valid: rsp_valid_q, data: c_rdata};

  operand_ram #(.DEPTH(MEM_DEPTH)) mem_a (
    .clk   (clk),
    .addr  (ab_addr),
    .wdata (host_cmd.data),
    .we    (host_cmd.write_a),
    .rdata (a_rdata)
  );

  operand_ram #(.DEPTH(MEM_DEPTH)) mem_b (
    .clk   (clk),
    .addr  (ab_addr),
    .wdata (host_cmd.data),
    .we    (host_cmd.write_b),
    .rdata (b_rdata)
  );

  operand_ram #(.DEPTH(MEM_DEPTH)) mem_c (
    .clk   (clk),
    .addr  (c_addr),
    .wdata (c_wdata),
    .we    (c_we),
    .rdata (c_rdata)
  );

  operand_feeder feeder_i (
    .clk     (clk),
    .reset   (reset),
    .start   (run_start),
    .a_word  (a_rdata),
    .b_word  (b_rdata),
    .rd_addr (feed_addr),
    .clear   (clear),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .capture (capture)
  );

  systolic_array array_i (
    .clk     (clk),
    .reset   (reset),
    .clear   (clear),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .results (results)
  );

  result_drain drain_i (
    .clk     (clk),
    .reset   (reset),
    .capture (capture),
    .results (results),
    .c_addr  (drain_addr),
    .c_wdata (c_wdata),
    .c_we    (c_we),
    .done    (done)
  );

  // host stays off the memories during a run
  assert property (@(posedge clk) disable iff (reset)
    busy |-> !(host_cmd.write_a || host_cmd.write_b || host_cmd.read_c))
    else $error("host command issued while a run is in progress");

  assert property (@(posedge clk) disable iff (reset) start |-> !busy)
    else $error("start issued while a run is in progress");

  assert property (@(posedge clk) disable iff (reset)
    !(host_cmd.write_a && host_cmd.write_b))
    else $error("write_a and write_b set in the same cycle");

endmodule

// File: verilog/result_drain.sv
`timescale 1ns/10ps

module result_drain (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   capture,
  input  matmul_pkg::elem_t [matmul_pkg::ARRAY_DIM*matmul_pkg::ARRAY_DIM-1:0] results,
  output matmul_pkg::addr_t      c_addr,
  output matmul_pkg::lane_word_t c_wdata,
  output logic                   c_we,
  output logic                   done
);

  localparam int DIM = matmul_pkg::ARRAY_DIM;
  localparam int COL_W = $clog2(DIM);

  typedef enum logic {IDLE, WRITE} state_t;

  state_t state;
  logic [COL_W-1:0] col;
  matmul_pkg::elem_t [DIM*DIM-1:0] held;

  // snapshot of the grid, frees the array for the next run
  always_ff @(posedge clk) begin
    if (capture) begin
      held <= results;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      col <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (capture) begin
            state <= WRITE;
            col <= '0;
          end
        end
        WRITE: begin
          col <= col + 1'b1;
          if (col == COL_W'(DIM - 1)) begin
            state <= IDLE;
            done <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign c_we = (state == WRITE);
  assign c_addr = matmul_pkg::addr_t'(col);

  // column word, lane i = C[i][col]
  always_comb begin
    for (int i = 0; i < DIM; i++) begin
      c_wdata[i] = held[i*DIM + int'(col)];
    end
  end

  // a new capture must not arrive while columns are still going out
  assert property (@(posedge clk) disable iff (reset)
    c_we |-> (state == WRITE) && !capture)
    else $error("result_drain got capture during column writes");

endmodule

// File: verilog/operand_feeder.sv
`timescale 1ns/10ps

module operand_feeder (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  matmul_pkg::lane_word_t a_word,
  input  matmul_pkg::lane_word_t b_word,
  output matmul_pkg::addr_t      rd_addr,
  output logic                   clear,
  output matmul_pkg::lane_word_t a_lanes,
  output matmul_pkg::lane_word_t b_lanes,
  output logic                   capture
);

  localparam int DIM = matmul_pkg::ARRAY_DIM;
  localparam int EW = matmul_pkg::ELEM_W;
  // the first word leaves memory one cycle after address 0
  localparam int CAPTURE_CNT = matmul_pkg::CAPTURE_DELAY + 1;
  localparam int CNT_W = $clog2(CAPTURE_CNT + 1);

  typedef enum logic [1:0] {IDLE, FEED, FLUSH} state_t;

  state_t state;
  logic [CNT_W-1:0] cnt;
  logic word_valid;
  // a and b of one lane travel together, {b, a}
  logic [2*EW-1:0] pair_in [DIM];
  logic [2*EW-1:0] pair_out [DIM];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= FEED;
            cnt <= '0;
          end
        end
        FEED: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(DIM - 1)) begin
            state <= FLUSH;
          end
        end
        FLUSH: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(CAPTURE_CNT)) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // memory data lags the address by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= (state == FEED);
    end
  end

  assign rd_addr = (state == FEED) ? matmul_pkg::addr_t'(cnt) : '0;
  assign clear = (state == FEED) && (cnt == '0);
  assign capture = (state == FLUSH) && (cnt == CNT_W'(CAPTURE_CNT));

  // zero lanes outside the feed window
  always_comb begin
    for (int i = 0; i < DIM; i++) begin
      pair_in[i] = word_valid ? {b_word[i], a_word[i]} : '0;
    end
  end

  // triangular skew, lane i waits i cycles
  for (genvar i = 0; i < DIM; i++) begin : g_skew
    if (i == 0) begin : g_direct
      assign pair_out[i] = pair_in[i];
    end else begin : g_delay
      logic [2*EW-1:0] dly [i];

      always_ff @(posedge clk) begin
        if (reset) begin
          dly <= '{default: '0};
        end else begin
          dly[0] <= pair_in[i];
          for (int k = 1; k < i; k++) begin
            dly[k] <= dly[k-1];
          end
        end
      end

      assign pair_out[i] = dly[i-1];
    end
  end

  always_comb begin
    for (int i = 0; i < DIM; i++) begin
      a_lanes[i] = pair_out[i][EW-1:0];
      b_lanes[i] = pair_out[i][2*EW-1:EW];
    end
  end

  // the drain samples a fixed distance after the clear of the same run
  assert property (@(posedge clk) disable iff (reset)
    capture |-> (state == FLUSH) && $past(clear, CAPTURE_CNT))
    else $error("capture outside flush or off its clear by more than %0d", CAPTURE_CNT);

endmodule

// File: verilog/systolic_array.sv
`timescale 1ns/10ps

module systolic_array (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear,
  input  matmul_pkg::lane_word_t a_lanes,
  input  matmul_pkg::lane_word_t b_lanes,
  output matmul_pkg::elem_t [matmul_pkg::ARRAY_DIM*matmul_pkg::ARRAY_DIM-1:0] results
);

  localparam int DIM = matmul_pkg::ARRAY_DIM;

  // horizontal a links, column DIM is the unused right edge
  matmul_pkg::elem_t a_h [DIM][DIM+1];
  // vertical b links, row DIM is the unused bottom edge
  matmul_pkg::elem_t b_v [DIM+1][DIM];
  matmul_pkg::elem_t pe_result [DIM][DIM];

  for (genvar e = 0; e < DIM; e++) begin : g_edge
    assign a_h[e][0] = a_lanes[e];
    assign b_v[0][e] = b_lanes[e];
  end

  for (genvar i = 0; i < DIM; i++) begin : g_row
    for (genvar j = 0; j < DIM; j++) begin : g_col
      processing_element pe_i (
        .clk    (clk),
        .reset  (reset),
        .clear  (clear),
        .in_a   (a_h[i][j]),
        .in_b   (b_v[i][j]),
        .out_a  (a_h[i][j+1]),
        .out_b  (b_v[i+1][j]),
        .result (pe_result[i][j])
      );
    end
  end

  // row-major, cell (i, j) at i*DIM + j
  always_comb begin
    for (int i = 0; i < DIM; i++) begin
      for (int j = 0; j < DIM; j++) begin
        results[i*DIM+j] = pe_result[i][j];
      end
    end
  end

endmodule

// File: verilog/processing_element.sv
`timescale 1ns/10ps

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  matmul_pkg::elem_t in_a,
  input  matmul_pkg::elem_t in_b,
  output matmul_pkg::elem_t out_a,
  output matmul_pkg::elem_t out_b,
  output matmul_pkg::elem_t result
);

  localparam int EW = matmul_pkg::ELEM_W;

  matmul_pkg::acc_t acc;
  matmul_pkg::acc_t product;

  assign product = matmul_pkg::acc_t'(in_a) * matmul_pkg::acc_t'(in_b);

  // a moves right, b moves down, one cycle per hop
  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
      acc <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
      if (clear) begin
        acc <= '0;
      end else begin
        acc <= acc + product;
      end
    end
  end

  // saturate when the upper half is in use
  assign result = (acc[2*EW-1:EW] != '0) ? matmul_pkg::SAT_VALUE : acc[EW-1:0];

endmodule

// File: verilog/operand_ram.sv
`timescale 1ns/10ps

module operand_ram #(
  parameter int DEPTH = matmul_pkg::MEM_DEPTH
) (
  input  logic                   clk,
  input  matmul_pkg::addr_t      addr,
  input  matmul_pkg::lane_word_t wdata,
  input  logic                   we,
  output matmul_pkg::lane_word_t rdata
);

  matmul_pkg::lane_word_t mem [DEPTH];

  // read returns the old word on a write to the same address
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

  // host and drain must stay inside the array when writing
  assert property (@(posedge clk) we |-> int'(addr) < DEPTH)
    else $error("operand_ram write to address %0d beyond depth %0d", addr, DEPTH);

endmodule

// File: verilog/host_pkg.sv
package host_pkg;

  // one host command per cycle, at most one strobe set
  typedef struct packed {
    logic                   write_a;
    logic                   write_b;
    logic                   read_c;
    matmul_pkg::addr_t      addr;
    matmul_pkg::lane_word_t data;
  } host_cmd_t;

  // answer to read_c, two cycles after the strobe
  typedef struct packed {
    logic                   valid;
    matmul_pkg::lane_word_t data;
  } read_rsp_t;

endpackage

// File: verilog/matmul_pkg.sv
package matmul_pkg;

  // array geometry and operand widths
  localparam int ARRAY_DIM = 4;
  localparam int ELEM_W = 16;
  localparam int ADDR_W = 7;
  localparam int MEM_DEPTH = 128;

  typedef logic [ELEM_W-1:0] elem_t;

  // full precision product sum
  typedef logic [2*ELEM_W-1:0] acc_t;

  typedef logic [ADDR_W-1:0] addr_t;

  // one memory word, lane 0 in the low bits
  typedef elem_t [ARRAY_DIM-1:0] lane_word_t;

  // reported when an accumulator no longer fits an element
  localparam elem_t SAT_VALUE = '1;

  // from the first operand word leaving memory until every cell is final:
  // 4 feed cycles, 3 skew cycles, 3 hops across the grid
  localparam int CAPTURE_DELAY = 10;

endpackage
